/* design/ttt_config.svh */
`ifndef TTT_CONFIG_SVH
`define TTT_CONFIG_SVH

// --------------------
// Board geometry
// --------------------
`define TTT_NUM_CELLS 9         // 3x3 board
`define TTT_NUM_LINES 8         // Rows, columns, two diagonals

// --------------------
// Cell weights
// --------------------
// Weights are chosen so that one line sum tells who owns the line
`define TTT_HUMAN_WEIGHT 1
`define TTT_ROBOT_WEIGHT 4

// Clock edges from an accepted ready to round_done
`define TTT_ROUND_CYCLES 4

`endif

/* design/ttt_pkg.sv */
`default_nettype none

`include "ttt_config.svh"

package ttt_pkg;

    // --------------------
    // Board contents
    // --------------------
    typedef enum logic [2:0] {
        EMPTY = 3'd0,
        HUMAN = 3'(`TTT_HUMAN_WEIGHT),
        ROBOT = 3'(`TTT_ROBOT_WEIGHT)
    } cell_t;

    typedef cell_t [`TTT_NUM_CELLS-1:0] board_t;    // Index 0 is cell 1

    typedef logic [3:0] cell_num_t;                  // 1..9, 0 means none
    typedef logic [3:0] line_sum_t;
    typedef line_sum_t [`TTT_NUM_LINES-1:0] line_sums_t;

    // --------------------
    // Judging results
    // --------------------
    typedef enum logic [1:0] {
        NONE      = 2'd0,
        DRAW      = 2'd1,
        HUMAN_WIN = 2'd2,
        ROBOT_WIN = 2'd3
    } result_t;

    typedef logic [3:0] line_num_t;                  // 1..8 line, 9 draw

    typedef cell_num_t line_cells_t [`TTT_NUM_LINES][3];

    // Rows, then columns, then the two diagonals
    localparam line_cells_t LINE_CELLS = '{
        '{4'd1, 4'd2, 4'd3},
        '{4'd4, 4'd5, 4'd6},
        '{4'd7, 4'd8, 4'd9},
        '{4'd1, 4'd4, 4'd7},
        '{4'd2, 4'd5, 4'd8},
        '{4'd3, 4'd6, 4'd9},
        '{4'd1, 4'd5, 4'd9},
        '{4'd3, 4'd5, 4'd7}
    };

    // Cell lookup by its 1-based number
    function automatic cell_t cell_at(board_t b, cell_num_t n);
        return b[n - 1];
    endfunction

endpackage

`default_nettype wire

/* design/board_if.sv */
`default_nettype none

interface board_if import ttt_pkg::*; ();

    board_t     board;      // Registered board
    line_sums_t sums;       // Per-line weight sums
    result_t    result;     // Judgement of the current board
    line_num_t  win_line;   // Winning line code

    // --------------------
    // Modports
    // --------------------
    modport store (
        output board
    );

    modport judge (
        input  board,
        output sums,
        output result,
        output win_line
    );

    // Planner and sequencer only look
    modport view (
        input board,
        input sums,
        input result,
        input win_line
    );

endinterface

`default_nettype wire

/* design/board_store.sv */
`default_nettype none

`include "ttt_config.svh"

module board_store import ttt_pkg::*; (
    input  logic                      sys_clk,
    input  logic                      sys_rst_n,
    input  logic [`TTT_NUM_CELLS-1:0] cell_sensor,
    input  logic                      capture_en,
    input  logic                      place_en,
    input  cell_num_t                 place_cell,
    board_if.store                    bd
);

    board_t cells;

    // --------------------
    // Cell registers
    // --------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < `TTT_NUM_CELLS; i++) begin
                cells[i] <= EMPTY;                      // Empty board
            end
        end else begin
            for (int i = 0; i < `TTT_NUM_CELLS; i++) begin
                // Person's pieces, only into free cells
                if (capture_en && cell_sensor[i] && cells[i] == EMPTY) begin
                    cells[i] <= HUMAN;
                end
                // Robot's piece at the chosen cell
                if (place_en && place_cell == cell_num_t'(i + 1)) begin
                    cells[i] <= ROBOT;
                end
            end
        end
    end

    assign bd.board = cells;

endmodule

`default_nettype wire

/* design/line_evaluator.sv */
`default_nettype none

`include "ttt_config.svh"

module line_evaluator import ttt_pkg::*; (
    board_if.judge bd
);

    localparam line_sum_t ROBOT_LINE = line_sum_t'(3 * `TTT_ROBOT_WEIGHT);    // 12
    localparam line_sum_t HUMAN_LINE = line_sum_t'(3 * `TTT_HUMAN_WEIGHT);    // 3

    line_sums_t sums;
    logic       any_robot;
    logic       any_human;
    logic       any_empty;
    line_num_t  first_line;

    // --------------------
    // Line sums
    // --------------------
    always_comb begin
        for (int l = 0; l < `TTT_NUM_LINES; l++) begin
            sums[l] = line_sum_t'(cell_at(bd.board, LINE_CELLS[l][0]))
                    + line_sum_t'(cell_at(bd.board, LINE_CELLS[l][1]))
                    + line_sum_t'(cell_at(bd.board, LINE_CELLS[l][2]));
        end
    end

    // Scan backwards so the first complete line in table order wins
    always_comb begin
        any_robot  = 1'b0;
        any_human  = 1'b0;
        first_line = '0;
        for (int l = `TTT_NUM_LINES - 1; l >= 0; l--) begin
            if (sums[l] == ROBOT_LINE) begin
                any_robot  = 1'b1;
                first_line = line_num_t'(l + 1);
            end else if (sums[l] == HUMAN_LINE) begin
                any_human  = 1'b1;
                first_line = line_num_t'(l + 1);
            end
        end
    end

    always_comb begin
        any_empty = 1'b0;
        for (int i = 0; i < `TTT_NUM_CELLS; i++) begin
            any_empty |= (bd.board[i] == EMPTY);
        end
    end

    // --------------------
    // Judgement
    // --------------------
    assign bd.sums     = sums;
    assign bd.result   = any_robot  ? ROBOT_WIN :
                         any_human  ? HUMAN_WIN :
                         !any_empty ? DRAW      : NONE;
    assign bd.win_line = (any_robot || any_human) ? first_line :
                         !any_empty               ? line_num_t'(9) : '0;

endmodule

`default_nettype wire

/* design/move_planner.sv */
`default_nettype none

`include "ttt_config.svh"

module move_planner import ttt_pkg::*; (
    board_if.view     bd,
    output cell_num_t choice
);

    localparam line_sum_t ROBOT_PAIR = line_sum_t'(2 * `TTT_ROBOT_WEIGHT);    // 8
    localparam line_sum_t HUMAN_PAIR = line_sum_t'(2 * `TTT_HUMAN_WEIGHT);    // 2

    // Centre, corners, then edges
    localparam cell_num_t PRIO_ORDER [`TTT_NUM_CELLS] = '{
        4'd5, 4'd1, 4'd3, 4'd7, 4'd9, 4'd2, 4'd4, 4'd6, 4'd8
    };

    cell_num_t win_cell;
    cell_num_t block_cell;
    cell_num_t prio_cell;
    logic      anti_fork;

    // --------------------
    // Helpers
    // --------------------
    // First empty cell of line l, 0 if full
    function automatic cell_num_t line_gap(board_t b, int l);
        cell_num_t gap;
        gap = '0;
        for (int k = 2; k >= 0; k--) begin
            if (cell_at(b, LINE_CELLS[l][k]) == EMPTY) begin
                gap = LINE_CELLS[l][k];
            end
        end
        return gap;
    endfunction

    // Gap of the first line whose sum matches target
    function automatic cell_num_t pair_gap(board_t b, line_sums_t s, line_sum_t target);
        cell_num_t pick;
        pick = '0;
        for (int l = `TTT_NUM_LINES - 1; l >= 0; l--) begin
            if (s[l] == target) begin
                pick = line_gap(b, l);
            end
        end
        return pick;
    endfunction

    // Person on two opposite corners, robot in the centre, nothing else
    function automatic logic fork_setup(board_t b, cell_num_t a, cell_num_t c);
        logic  ok;
        cell_t want;
        ok = 1'b1;
        for (int i = 1; i <= `TTT_NUM_CELLS; i++) begin
            if (i == a || i == c) begin
                want = HUMAN;
            end else if (i == 5) begin
                want = ROBOT;
            end else begin
                want = EMPTY;
            end
            ok &= (cell_at(b, cell_num_t'(i)) == want);
        end
        return ok;
    endfunction

    // --------------------
    // Rule evaluation
    // --------------------
    assign win_cell   = pair_gap(bd.board, bd.sums, ROBOT_PAIR);
    assign block_cell = pair_gap(bd.board, bd.sums, HUMAN_PAIR);
    assign anti_fork  = fork_setup(bd.board, 4'd1, 4'd9) || fork_setup(bd.board, 4'd3, 4'd7);

    always_comb begin
        prio_cell = '0;
        for (int p = `TTT_NUM_CELLS - 1; p >= 0; p--) begin
            if (cell_at(bd.board, PRIO_ORDER[p]) == EMPTY) begin
                prio_cell = PRIO_ORDER[p];
            end
        end
    end

    assign choice = (win_cell != '0)   ? win_cell   :    // Complete own line
                    (block_cell != '0) ? block_cell :    // Block the person
                    anti_fork          ? 4'd2       :    // Edge against double corner
                                         prio_cell;

endmodule

`default_nettype wire

/* design/game_sequencer.sv */
`default_nettype none

module game_sequencer import ttt_pkg::*; (
    input  logic      sys_clk,
    input  logic      sys_rst_n,
    input  logic      ready,
    board_if.view     bd,
    input  cell_num_t choice,
    output logic      capture_en,
    output logic      place_en,
    output cell_num_t place_cell,
    output cell_num_t motor_cell,
    output result_t   result,
    output line_num_t win_line,
    output logic      round_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CAPTURE,
        S_JUDGE,
        S_PLACE,
        S_DONE
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   robot_turn;     // Game still open after the person's move
    logic   accept;

    // Strobes outside IDLE or after game end are dropped
    assign accept = ready && (result == NONE);

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:    if (accept) state_nxt = S_CAPTURE;
            S_CAPTURE: state_nxt = S_JUDGE;
            S_JUDGE:   state_nxt = S_PLACE;
            S_PLACE:   state_nxt = S_DONE;
            S_DONE:    state_nxt = S_IDLE;
            default:   state_nxt = S_IDLE;
        endcase
    end

    assign capture_en = (state == S_CAPTURE);
    assign place_en   = (state == S_PLACE) && robot_turn;
    assign place_cell = choice;

    // --------------------
    // State and held outputs
    // --------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state      <= S_IDLE;
            robot_turn <= 1'b0;
            motor_cell <= '0;
            result     <= NONE;
            win_line   <= '0;
            round_done <= 1'b0;
        end else begin
            state      <= state_nxt;
            round_done <= (state == S_DONE);                    // One-cycle pulse
            if (state == S_JUDGE) begin
                robot_turn <= (bd.result == NONE);
            end
            if (state == S_PLACE) begin
                motor_cell <= robot_turn ? choice : cell_num_t'(0);
            end
            if (state == S_DONE) begin
                result   <= bd.result;                          // Board after robot move
                win_line <= bd.win_line;
            end
        end
    end

endmodule

`default_nettype wire

/* design/tic_tac_toe_top.sv */
`default_nettype none

`include "ttt_config.svh"

module tic_tac_toe_top import ttt_pkg::*; (
    input  logic                      sys_clk,
    input  logic                      sys_rst_n,
    input  logic [`TTT_NUM_CELLS-1:0] cell_sensor,
    input  logic                      ready,
    output cell_num_t                 motor_cell,
    output result_t                   result,
    output line_num_t                 win_line,
    output logic                      round_done
);

    logic      capture_en;
    logic      place_en;
    cell_num_t place_cell;
    cell_num_t choice;

    board_if bd_bus ();     // Board and its judgement

    // --------------------
    // Datapath
    // --------------------
    board_store u_board_store (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .cell_sensor (cell_sensor),
        .capture_en  (capture_en),
        .place_en    (place_en),
        .place_cell  (place_cell),
        .bd          (bd_bus.store)
    );

    line_evaluator u_line_evaluator (
        .bd (bd_bus.judge)
    );

    move_planner u_move_planner (
        .bd     (bd_bus.view),
        .choice (choice)
    );

    // --------------------
    // Control
    // --------------------
    game_sequencer u_game_sequencer (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .ready      (ready),
        .bd         (bd_bus.view),
        .choice     (choice),
        .capture_en (capture_en),
        .place_en   (place_en),
        .place_cell (place_cell),
        .motor_cell (motor_cell),
        .result     (result),
        .win_line   (win_line),
        .round_done (round_done)
    );

endmodule

`default_nettype wire

/* tests/ttt_sva.sv */
`default_nettype none

`include "ttt_config.svh"

module ttt_sva import ttt_pkg::*; (
    input logic      sys_clk,
    input logic      sys_rst_n,
    input logic      ready,
    input cell_num_t motor_cell,
    input result_t   result,
    input line_num_t win_line,
    input logic      round_done
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;
    logic [2:0]  busy_cnt;          // Edges left in the running round
    logic        accepted;

    assign accepted = ready && (result == NONE) && (busy_cnt == '0);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            busy_cnt <= '0;
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 3'd1;
        end else if (accepted) begin
            busy_cnt <= 3'(`TTT_ROUND_CYCLES);
        end
    end

    // --------------------
    // Round protocol
    // --------------------
    a_round_latency: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        accepted |=> !round_done [*`TTT_ROUND_CYCLES] ##1 round_done ##1 !round_done)
        else begin
            fail_count++;
            $error("round_done missing, early or wider than one cycle");
        end

    // Every pulse closes an accepted round
    a_done_cause: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $rose(round_done) |-> $past(accepted, `TTT_ROUND_CYCLES + 1))
        else begin
            fail_count++;
            $error("round_done without an accepted ready");
        end

    a_outputs_held: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        busy_cnt == '0 |=> $stable(motor_cell) && $stable(result) && $stable(win_line))
        else begin
            fail_count++;
            $error("Outputs changed between rounds");
        end

    a_reset_values: assert property (@(posedge sys_clk)
        !sys_rst_n |-> motor_cell == '0 && result == NONE && win_line == '0 && !round_done)
        else begin
            fail_count++;
            $error("Outputs not cleared by reset");
        end

endmodule

bind tic_tac_toe_top ttt_sva u_sva (
    .sys_clk    (sys_clk),
    .sys_rst_n  (sys_rst_n),
    .ready      (ready),
    .motor_cell (motor_cell),
    .result     (result),
    .win_line   (win_line),
    .round_done (round_done)
);

`default_nettype wire

/* tests/ttt_tb.sv */
`default_nettype none

`include "ttt_config.svh"

module ttt_tb import ttt_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RANDOM_GAMES = 40;
    localparam int NUM_GAMES    = 4 + RANDOM_GAMES;
    localparam int WAIT_LIMIT   = 4 * `TTT_ROUND_CYCLES;
    localparam int PRIO [9]     = '{5, 1, 3, 7, 9, 2, 4, 6, 8};    // Centre, corners, edges
    localparam int TRIPLES [8][3] = '{
        '{1, 2, 3}, '{4, 5, 6}, '{7, 8, 9},
        '{1, 4, 7}, '{2, 5, 8}, '{3, 6, 9},
        '{1, 5, 9}, '{3, 5, 7}
    };

    logic        sys_clk;
    logic        sys_rst_n;
    logic [8:0]  cell_sensor;
    logic        ready;
    cell_num_t   motor_cell;
    result_t     result;
    line_num_t   win_line;
    logic        round_done;
    int          model [1:9];            // 0 empty, 1 person, 4 robot
    logic [31:0] lfsr = 32'h7f885d11;
    int          value_errors = 0;
    int          protocol_errors = 0;

    tic_tac_toe_top DUT (.*);

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    // --------------------
    // Reference model
    // --------------------
    function automatic int line_sum(int l);
        return model[TRIPLES[l][0]] + model[TRIPLES[l][1]] + model[TRIPLES[l][2]];
    endfunction

    function automatic void judge(output result_t r, output line_num_t wl);
        int empties;
        r = NONE;
        wl = '0;
        empties = 0;
        foreach (model[c]) begin
            if (model[c] == 0) empties++;
        end
        for (int l = 0; l < 8; l++) begin
            if (line_sum(l) == 12 || line_sum(l) == 3) begin
                if (wl == '0) wl = line_num_t'(l + 1);    // First full line in table order
                if (line_sum(l) == 12) r = ROBOT_WIN;
                else if (r == NONE) r = HUMAN_WIN;
            end
        end
        if (wl == '0 && empties == 0) begin
            r = DRAW;
            wl = 4'd9;
        end
    endfunction

    // Free cell of the first line with the given sum
    function automatic int first_gap(int target);
        for (int l = 0; l < 8; l++) begin
            for (int k = 0; k < 3; k++) begin
                if (line_sum(l) == target && model[TRIPLES[l][k]] == 0) return TRIPLES[l][k];
            end
        end
        return 0;
    endfunction

    function automatic int robot_choice();
        int pick;
        int total;
        total = 0;
        foreach (model[c]) total += model[c];
        pick = first_gap(8);                              // Win
        if (pick == 0) pick = first_gap(2);               // Block
        if (pick == 0 && total == 6 && model[5] == 4 &&
            ((model[1] == 1 && model[9] == 1) || (model[3] == 1 && model[7] == 1))) begin
            pick = 2;                                     // Anti-fork
        end
        for (int p = 0; p < 9; p++) begin
            if (pick == 0 && model[PRIO[p]] == 0) pick = PRIO[p];
        end
        return pick;
    endfunction

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic logic [8:0] cell_mask(int c);
        return 9'd1 << (c - 1);
    endfunction

    // --------------------
    // Checks and stimulus
    // --------------------
    task automatic check_value(string name, int expected, int actual);
        assert (expected == actual) else begin
            value_errors++;
            $display("ERROR %0t ns %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic expect_outputs(int motor, result_t res, line_num_t line);
        check_value("motor_cell", motor, int'(motor_cell));
        check_value("result", int'(res), int'(result));
        check_value("win_line", int'(line), int'(win_line));
    endtask

    task automatic reset_dut();
        @(posedge sys_clk);
        sys_rst_n   <= 1'b0;
        cell_sensor <= '0;
        ready       <= 1'b0;
        repeat (8) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        foreach (model[c]) model[c] = 0;
        @(negedge sys_clk);
        check_value("round_done", 0, int'(round_done));
        expect_outputs(0, NONE, 4'd0);
    endtask

    // Person adds the cells in mask and the DUT answers
    task automatic play_round(logic [8:0] mask);
        result_t   exp_result;
        line_num_t exp_line;
        int        exp_motor;
        int        waited;
        for (int c = 1; c <= 9; c++) begin
            if (mask[c - 1]) model[c] = 1;
        end
        judge(exp_result, exp_line);
        exp_motor = 0;
        if (exp_result == NONE) begin
            exp_motor = robot_choice();
            model[exp_motor] = 4;
            judge(exp_result, exp_line);
        end
        @(posedge sys_clk);
        cell_sensor <= cell_sensor | mask;
        ready       <= 1'b1;
        @(posedge sys_clk);
        ready <= 1'b0;
        waited = 0;
        while (!round_done && waited < WAIT_LIMIT) begin
            @(negedge sys_clk);
            waited++;
        end
        assert (round_done) else begin
            protocol_errors++;
            $display("No round_done arrived after an accepted ready at %0t ns", $time);
        end
        if (round_done) expect_outputs(exp_motor, exp_result, exp_line);
    endtask

    task automatic ready_ignored();
        int seen;
        seen = 0;
        @(posedge sys_clk);
        ready <= 1'b1;
        @(posedge sys_clk);
        ready <= 1'b0;
        repeat (`TTT_ROUND_CYCLES + 4) begin
            @(negedge sys_clk);
            if (round_done) seen++;
        end
        assert (seen == 0) else begin
            protocol_errors++;
            $display("A ready after the end of the game still gave round_done at %0t ns", $time);
        end
    endtask

    task automatic random_game();
        result_t   r;
        line_num_t wl;
        int        empties;
        int        pick;
        int        target;
        reset_dut();
        judge(r, wl);
        for (int round = 0; round < 9 && r == NONE; round++) begin
            empties = 0;
            target  = 0;
            foreach (model[c]) begin
                if (model[c] == 0) empties++;
            end
            pick = rand_bits(4) % empties;
            for (int c = 1; c <= 9; c++) begin
                if (model[c] == 0) begin
                    if (pick == 0) target = c;
                    pick--;
                end
            end
            play_round(cell_mask(target));
            judge(r, wl);
        end
        ready_ignored();
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        sys_clk     = 1'b0;
        sys_rst_n   = 1'b0;
        cell_sensor = '0;
        ready       = 1'b0;
        reset_dut();                                      // Centre reply, then anti-fork
        play_round(cell_mask(1));
        expect_outputs(5, NONE, 4'd0);
        play_round(cell_mask(9));
        expect_outputs(2, NONE, 4'd0);
        reset_dut();                                      // Block on the top row
        play_round(cell_mask(1));
        play_round(cell_mask(2));
        expect_outputs(3, NONE, 4'd0);
        play_round(cell_mask(4));                         // Robot completes 3-5-7
        expect_outputs(7, ROBOT_WIN, 4'd8);
        ready_ignored();
        reset_dut();                                      // Person forks and wins on 1-4-7
        play_round(cell_mask(1));
        play_round(cell_mask(7) | cell_mask(9));
        expect_outputs(8, NONE, 4'd0);
        play_round(cell_mask(4));
        expect_outputs(0, HUMAN_WIN, 4'd4);
        ready_ignored();
        reset_dut();                                      // Full board, no line
        play_round(cell_mask(5));
        play_round(cell_mask(9));
        play_round(cell_mask(2));
        play_round(cell_mask(4));
        play_round(cell_mask(7));
        expect_outputs(0, DRAW, 4'd9);
        repeat (RANDOM_GAMES) random_game();
        repeat (3) @(posedge sys_clk);
        $display("Errors: %0d value, %0d protocol, %0d assertion",
                 value_errors, protocol_errors, DUT.u_sva.fail_count);
        if (value_errors + protocol_errors + int'(DUT.u_sva.fail_count) == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(NUM_GAMES * 10 * 10 * CLK_PERIOD);
        $display("Watchdog expired before all games were played");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+design
design/ttt_pkg.sv
design/board_if.sv
design/board_store.sv
design/line_evaluator.sv
design/move_planner.sv
design/game_sequencer.sv
design/tic_tac_toe_top.sv
tests/ttt_sva.sv
tests/ttt_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ttt_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
